/* vlog.f */
rtl/ib_pkg.sv
rtl/dbg_cmd_xlate.sv
rtl/ib_write_ctl.sv
rtl/ib_slot.sv
rtl/dec_ib_ctl.sv
verif/ib_checker.sv
verif/tb_dec_ib_ctl.sv

/* run.sh */
#!/usr/bin/env bash
# builds the instruction buffer testbench with verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f vlog.f --top-module tb_dec_ib_ctl

out=$(./obj_dir/Vtb_dec_ib_ctl 2>&1) || { echo "$out"; echo "simulation exited with an error"; exit 1; }
echo "$out"

if echo "$out" | grep -qx "TEST PASSED"; then
   exit 0
fi
exit 1

/* verif/tb_dec_ib_ctl.sv */
// directed testbench for the decode instruction buffer against a queue model of slot order
`timescale 1ns/1ps

module tb_dec_ib_ctl import ib_pkg::*; ();

   logic                clk;
   logic                rst_n;
   fetch_t              fetch_i0;
   fetch_t              fetch_i1;
   dbg_cmd_t            dbg_cmd;
   logic                exu_flush_final;
   logic                dec_i0_decode;
   logic                dec_i1_decode;
   logic [IB_DEPTH-1:0] ib_valid;
   ib_entry_t           dec_i0_entry;
   ib_entry_t           dec_i1_entry;
   logic                dec_debug_wdata_rs1;
   logic                dec_debug_fence;

   logic [31:0] lfsr = 32'h74e8_cc19;
   ib_entry_t   model_q [$];                // expected contents from slot 0 up
   logic        model_flush;                // flush seen by the model last cycle
   string       cur_test;
   int          test_err_start;
   int          errors;
   int          checks;
   int          tests;

   dec_ib_ctl u_dec_ib_ctl (
      .clk                 (clk),
      .rst_n               (rst_n),
      .fetch_i0            (fetch_i0),
      .fetch_i1            (fetch_i1),
      .dbg_cmd             (dbg_cmd),
      .exu_flush_final     (exu_flush_final),
      .dec_i0_decode       (dec_i0_decode),
      .dec_i1_decode       (dec_i1_decode),
      .ib_valid            (ib_valid),
      .dec_i0_entry        (dec_i0_entry),
      .dec_i1_entry        (dec_i1_entry),
      .dec_debug_wdata_rs1 (dec_debug_wdata_rs1),
      .dec_debug_fence     (dec_debug_fence)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // galois form of x^32 + x^22 + x^2 + x + 1
   function automatic logic rand_bit();
      logic lsb;
      lsb  = lfsr[0];
      lfsr = lfsr >> 1;
      if (lsb)
         lfsr = lfsr ^ 32'h8020_0003;
      return lsb;
   endfunction

   function automatic logic [31:0] rand_bits(int n);
      logic [31:0] r;
      r = '0;
      for (int k = 0; k < n; k++)
         r = {r[30:0], rand_bit()};
      return r;
   endfunction

   function automatic ib_entry_t make_entry();
      ib_entry_t   e;
      logic [31:0] r;
      e.instr = rand_bits(32);
      r       = rand_bits(31);
      e.pc    = r[30:0];
      e.pc4   = rand_bit();
      e.icaf  = rand_bit();
      e.perr  = rand_bit();
      e.sbecc = rand_bit();
      e.dbecc = rand_bit();
      return e;
   endfunction

   task automatic check(input logic ok, input string msg);
      checks++;
      assert (ok) else begin
         $display("CHECK FAILED at %0d ns: %s: %s", $time, cur_test, msg);
         errors++;
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;                                   // drive and sample just after the edge
   endtask

   task automatic drive_idle();
      fetch_i0        = '0;
      fetch_i1        = '0;
      dbg_cmd         = '0;
      exu_flush_final = 1'b0;
      dec_i0_decode   = 1'b0;
      dec_i1_decode   = 1'b0;
   endtask

   task automatic check_outputs();
      logic [IB_DEPTH-1:0] mask;
      mask = IB_DEPTH'((1 << model_q.size()) - 1);
      check(ib_valid == mask, $sformatf("ib_valid %b, expected %b", ib_valid, mask));
      if (model_q.size() > 0)
         check(dec_i0_entry == model_q[0],
               $sformatf("slot 0 holds %h, expected %h", dec_i0_entry, model_q[0]));
      if (model_q.size() > 1)
         check(dec_i1_entry == model_q[1],
               $sformatf("slot 1 holds %h, expected %h", dec_i1_entry, model_q[1]));
   endtask

   // one cycle of fetch and decode against the queue model
   task automatic run_cycle(input int fetch_n, input int dec_n, input logic flush);
      ib_entry_t e0;
      ib_entry_t e1;
      int        n;
      n                = model_q.size();  // room is judged before the shift
      e0               = make_entry();
      e1               = make_entry();
      fetch_i0.valid   = fetch_n >= 1;
      fetch_i0.entry   = e0;
      fetch_i1.valid   = fetch_n >= 2;
      fetch_i1.entry   = e1;
      exu_flush_final  = flush;
      dec_i0_decode    = dec_n >= 1;
      dec_i1_decode    = dec_n >= 2;
      for (int k = 0; k < dec_n; k++)
         void'(model_q.pop_front());
      if (!model_flush && fetch_n >= 1 && n < IB_DEPTH)
         model_q.push_back(e0);
      if (!model_flush && fetch_n >= 2 && n < IB_DEPTH - 1)
         model_q.push_back(e1);
      if (model_flush)
         model_q.delete();
      model_flush = flush;
      next_cycle();
      drive_idle();
      check_outputs();
   endtask

   task automatic run_debug(input logic write, input logic [1:0] cmd_type,
                            input logic [11:0] addr, input logic [31:0] exp_instr,
                            input logic exp_fence);
      logic loads;
      loads            = cmd_type != 2'd2;   // memory commands never reach the buffer
      dbg_cmd.valid    = 1'b1;
      dbg_cmd.write    = write;
      dbg_cmd.cmd_type = cmd_type;
      dbg_cmd.addr     = addr;
      next_cycle();
      drive_idle();
      if (loads) begin
         check(ib_valid == 4'b0001, $sformatf("cmd %h: ib_valid %b", addr, ib_valid));
         check(dec_i0_entry.instr == exp_instr, $sformatf("cmd %h: instr %h, expected %h",
               addr, dec_i0_entry.instr, exp_instr));
      end else
         check(ib_valid == '0, "memory command loaded the buffer");
      check(dec_debug_wdata_rs1 == (write & loads), $sformatf("cmd %h: rs1 flag wrong", addr));
      check(dec_debug_fence == exp_fence, $sformatf("cmd %h: fence flag wrong", addr));
      dec_i0_decode = loads;
      next_cycle();
      drive_idle();
      check(ib_valid == '0 && !dec_debug_wdata_rs1 && !dec_debug_fence,
            $sformatf("cmd %h: slot 0 or a flag outlived one cycle", addr));
   endtask

   task automatic open_test(input string name);
      cur_test       = name;
      test_err_start = errors;
   endtask

   task automatic report_test();
      $display("%s: %0d errors", cur_test, errors - test_err_start);
      tests++;
   endtask

   task automatic reset_state();
      open_test("reset");
      check(ib_valid == '0, "ib_valid not clear after reset");
      check(!dec_debug_wdata_rs1 && !dec_debug_fence, "debug flag set after reset");
      check(dec_i0_entry == '0 && dec_i1_entry == '0, "slot contents not clear after reset");
      run_cycle(0, 0, 1'b0);
      report_test();
   endtask

   task automatic fill_and_backpressure();
      open_test("fill");
      run_cycle(2, 0, 1'b0);
      check(ib_valid == 4'b0011, "first pair not stored");
      run_cycle(2, 0, 1'b0);
      check(ib_valid == 4'b1111, "buffer not full after two pairs");
      run_cycle(2, 0, 1'b0);                // no room for the third pair
      check(ib_valid == 4'b1111, "refused pair changed ib_valid");
      run_cycle(0, 2, 1'b0);                // slots 2 and 3 must still hold the second pair
      report_test();
   endtask

   task automatic ordered_drain();
      int f;
      int d;
      open_test("drain");
      for (int k = 0; k < 200; k++) begin
         f = int'(rand_bits(2)) % 3;
         d = int'(rand_bits(2)) % 3;
         if (d > model_q.size())
            d = model_q.size();
         run_cycle(f, d, 1'b0);
      end
      while (model_q.size() > 0)
         run_cycle(0, (model_q.size() > 1) ? 2 : 1, 1'b0);
      report_test();
   endtask

   task automatic flush_while_full();
      open_test("flush");
      while (model_q.size() < IB_DEPTH)
         run_cycle(2, 0, 1'b0);
      run_cycle(0, 0, 1'b1);
      check(ib_valid == 4'b1111, "buffer changed in the flush cycle");
      run_cycle(2, 0, 1'b0);                // fetched while the flush is registered
      check(ib_valid == '0, "ib_valid not clear two cycles after flush");
      run_cycle(0, 0, 1'b0);
      check(ib_valid == '0, "instruction from after the flush appeared");
      run_cycle(1, 0, 1'b0);
      run_cycle(0, 1, 1'b0);
      report_test();
   endtask

   task automatic debug_commands();
      open_test("debug");
      run_debug(1'b0, DBG_TYPE_GPR, 12'd5, {7'd0, 5'd0, 5'd5, 3'b110, 5'd0, 7'b0110011}, 1'b0);
      run_debug(1'b1, DBG_TYPE_GPR, 12'd17, {7'd0, 5'd0, 5'd0, 3'b110, 5'd17, 7'b0110011}, 1'b0);
      run_debug(1'b0, DBG_TYPE_CSR, 12'h300, {12'h300, 5'd0, 3'b010, 5'd0, 7'b1110011}, 1'b0);
      run_debug(1'b1, DBG_TYPE_CSR, 12'h7b0, {12'h7b0, 5'd0, 3'b001, 5'd0, 7'b1110011}, 1'b0);
      run_debug(1'b1, DBG_TYPE_CSR, 12'h7c4, {12'h7c4, 5'd0, 3'b001, 5'd0, 7'b1110011}, 1'b1);
      run_debug(1'b1, DBG_TYPE_MEM, 12'h7c4, 32'h0, 1'b0);
      report_test();
   endtask

   initial begin
      errors      = 0;
      checks      = 0;
      tests       = 0;
      model_flush = 1'b0;
      rst_n       = 1'b0;
      drive_idle();
      repeat (8) @(posedge clk);
      #1;
      rst_n = 1'b1;
      reset_state();
      fill_and_backpressure();
      ordered_drain();
      flush_while_full();
      debug_commands();
      $display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
               tests, checks, errors, u_dec_ib_ctl.u_ib_checker.fail_count);
      if (errors == 0 && u_dec_ib_ctl.u_ib_checker.fail_count == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

   // watchdog sized from the per-test cycle budgets
   initial begin
      int budget;
      budget = 10 + 10 + 210 + 20 + 40;      // reset, fill, drain, flush, debug
      #((budget + 108) * 10);
      $display("watchdog: run did not finish within %0d cycles", budget + 108);
      $display("TEST FAILED");
      $finish;
   end

endmodule

/* verif/ib_checker.sv */
// concurrent protocol checks on the instruction buffer ports, attached to dec_ib_ctl by bind
`timescale 1ns/1ps

module ib_checker import ib_pkg::*; (
   input logic                clk,
   input logic                rst_n,
   input logic [IB_DEPTH-1:0] ib_valid,
   input logic                exu_flush_final,
   input logic                dec_i0_decode,
   input logic                dec_i1_decode,
   input logic                dec_debug_wdata_rs1,
   input logic                dec_debug_fence
);

   int fail_count = 0;

   // valid slots always form one run starting at slot 0
   valid_contiguous: assert property (@(posedge clk) disable iff (!rst_n)
      (ib_valid & (ib_valid + IB_DEPTH'(1))) == '0)
      else begin
         fail_count++;
         $error("ib_valid %b is not contiguous from slot 0", ib_valid);
      end

   i0_decode_valid: assert property (@(posedge clk) disable iff (!rst_n)
      dec_i0_decode |-> ib_valid[0])
      else begin
         fail_count++;
         $error("i0 decode without a valid slot 0");
      end

   i1_decode_valid: assert property (@(posedge clk) disable iff (!rst_n)
      dec_i1_decode |-> dec_i0_decode && ib_valid[1])
      else begin
         fail_count++;
         $error("i1 decode without i0 decode or a valid slot 1");
      end

   flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
      exu_flush_final |-> ##2 ib_valid == '0)
      else begin
         fail_count++;
         $error("buffer not empty two cycles after flush");
      end

   reset_flags_low: assert property (@(posedge clk)
      !rst_n |=> !dec_debug_wdata_rs1 && !dec_debug_fence)
      else begin
         fail_count++;
         $error("debug flag high in the cycle after reset");
      end

endmodule

bind dec_ib_ctl ib_checker u_ib_checker (
   .clk                 (clk),
   .rst_n               (rst_n),
   .ib_valid            (ib_valid),
   .exu_flush_final     (exu_flush_final),
   .dec_i0_decode       (dec_i0_decode),
   .dec_i1_decode       (dec_i1_decode),
   .dec_debug_wdata_rs1 (dec_debug_wdata_rs1),
   .dec_debug_fence     (dec_debug_fence)
);

/* rtl/dec_ib_ctl.sv */
// top of the decode instruction buffer: debug translator, write control and the slot array
`timescale 1ns/1ps

module dec_ib_ctl import ib_pkg::*; (
   input  logic                clk,
   input  logic                rst_n,
   input  fetch_t              fetch_i0,
   input  fetch_t              fetch_i1,
   input  dbg_cmd_t            dbg_cmd,
   input  logic                exu_flush_final,
   input  logic                dec_i0_decode,
   input  logic                dec_i1_decode,
   output logic [IB_DEPTH-1:0] ib_valid,
   output ib_entry_t           dec_i0_entry,
   output ib_entry_t           dec_i1_entry,
   output logic                dec_debug_wdata_rs1,
   output logic                dec_debug_fence
);

   logic      debug_valid;
   ib_entry_t load_i0;                     // i0 or the debug instruction
   slot_sel_t slot_sel [IB_DEPTH];
   ib_entry_t slot_q [IB_DEPTH+2];         // two zero entries past the top

   dbg_cmd_xlate u_dbg (
      .clk             (clk),
      .rst_n           (rst_n),
      .dbg_cmd         (dbg_cmd),
      .fetch_i0        (fetch_i0),
      .debug_valid     (debug_valid),
      .load_i0         (load_i0),
      .debug_wdata_rs1 (dec_debug_wdata_rs1),
      .debug_fence     (dec_debug_fence)
   );

   ib_write_ctl u_ctl (
      .clk             (clk),
      .rst_n           (rst_n),
      .exu_flush_final (exu_flush_final),
      .i0_valid        (fetch_i0.valid),
      .i1_valid        (fetch_i1.valid),
      .debug_valid     (debug_valid),
      .i0_decode       (dec_i0_decode),
      .i1_decode       (dec_i1_decode),
      .sel             (slot_sel),
      .ib_valid        (ib_valid)
   );

   assign slot_q[IB_DEPTH]   = '0;
   assign slot_q[IB_DEPTH+1] = '0;

   for (genvar k = 0; k < IB_DEPTH; k++) begin : g_slot
      ib_slot u_slot (
         .clk         (clk),
         .rst_n       (rst_n),
         .sel         (slot_sel[k]),
         .i0_entry    (load_i0),
         .i1_entry    (fetch_i1.entry),
         .next1_entry (slot_q[k+1]),
         .next2_entry (slot_q[k+2]),
         .entry       (slot_q[k])
      );
   end

   // decode reads the two bottom slots directly
   assign dec_i0_entry = slot_q[0];
   assign dec_i1_entry = slot_q[1];

endmodule

/* rtl/ib_slot.sv */
// one instruction buffer entry, loaded from fetch or shifted down from a higher slot
`timescale 1ns/1ps

module ib_slot import ib_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  slot_sel_t sel,
   input  ib_entry_t i0_entry,
   input  ib_entry_t i1_entry,
   input  ib_entry_t next1_entry,       // slot one above
   input  ib_entry_t next2_entry,       // slot two above
   output ib_entry_t entry
);

   ib_entry_t entry_nxt;

   always_comb begin
      case (sel)
         SEL_I0:    entry_nxt = i0_entry;
         SEL_I1:    entry_nxt = i1_entry;
         SEL_NEXT1: entry_nxt = next1_entry;
         SEL_NEXT2: entry_nxt = next2_entry;
         default:   entry_nxt = entry;   // hold
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n)
         entry <= '0;
      else
         entry <= entry_nxt;
   end

endmodule

/* rtl/ib_write_ctl.sv */
// slot valid tracking for the instruction buffer: flush register, room check and per-slot load selects
`timescale 1ns/1ps

module ib_write_ctl import ib_pkg::*; (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                exu_flush_final,
   input  logic                i0_valid,
   input  logic                i1_valid,
   input  logic                debug_valid,
   input  logic                i0_decode,
   input  logic                i1_decode,
   output slot_sel_t           sel [IB_DEPTH],
   output logic [IB_DEPTH-1:0] ib_valid
);

   logic                flush_final;          // flush seen last cycle
   logic                i0_val;
   logic                i1_val;
   logic                shift1;
   logic                shift2;
   logic [IB_DEPTH+1:0] val_pad;              // valids with two empty slots on top
   logic [IB_DEPTH-1:0] shift_val;
   logic [IB_DEPTH:0]   occ;
   logic [IB_DEPTH-1:0] first_free;
   logic [IB_DEPTH-1:0] wr_i0;
   logic [IB_DEPTH-1:0] wr_i1;
   logic [IB_DEPTH-1:0] ib_valid_nxt;

   always_ff @(posedge clk) begin
      if (!rst_n)
         flush_final <= 1'b0;
      else
         flush_final <= exu_flush_final;
   end

   // room is judged before the decode shift
   assign i0_val = i0_valid & ~ib_valid[IB_DEPTH-1] & ~flush_final;
   assign i1_val = i1_valid & ~ib_valid[IB_DEPTH-2] & ~flush_final;

   assign shift1 = i0_decode & ~i1_decode;
   assign shift2 = i0_decode &  i1_decode;

   assign val_pad = {2'b00, ib_valid};

   always_comb begin
      if (shift2)
         shift_val = val_pad[IB_DEPTH+1:2];
      else if (shift1)
         shift_val = val_pad[IB_DEPTH:1];
      else
         shift_val = ib_valid;
   end

   // a slot is the first free one when the slot below it is occupied
   assign occ        = {shift_val, 1'b1};
   assign first_free = occ[IB_DEPTH-1:0] & ~occ[IB_DEPTH:1];

   // debug only ever targets slot 0
   assign wr_i0 = (first_free & {IB_DEPTH{i0_val}}) |
                  {{(IB_DEPTH-1){1'b0}}, first_free[0] & debug_valid};
   assign wr_i1 = {first_free[IB_DEPTH-2:0], 1'b0} & {IB_DEPTH{i1_val}};   // i1 sits after i0

   always_comb begin
      for (int k = 0; k < IB_DEPTH; k++) begin
         if (wr_i0[k])
            sel[k] = SEL_I0;
         else if (wr_i1[k])
            sel[k] = SEL_I1;
         else if (shift1 && val_pad[k+1])
            sel[k] = SEL_NEXT1;
         else if (shift2 && val_pad[k+2])
            sel[k] = SEL_NEXT2;
         else
            sel[k] = SEL_HOLD;
      end
   end

   assign ib_valid_nxt = (shift_val | wr_i0 | wr_i1) & ~{IB_DEPTH{flush_final}};

   always_ff @(posedge clk) begin
      if (!rst_n)
         ib_valid <= '0;
      else
         ib_valid <= ib_valid_nxt;
   end

endmodule

/* rtl/dbg_cmd_xlate.sv */
// turns a debug gpr/csr command into an instruction for slot 0 and registers its side flags
`timescale 1ns/1ps

module dbg_cmd_xlate import ib_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  dbg_cmd_t  dbg_cmd,
   input  fetch_t    fetch_i0,
   output logic      debug_valid,
   output ib_entry_t load_i0,
   output logic      debug_wdata_rs1,
   output logic      debug_fence
);

   logic        is_gpr;
   logic        is_csr;
   logic [31:0] dbg_instr;
   logic        wdata_rs1_nxt;
   logic        fence_nxt;

   assign debug_valid = dbg_cmd.valid & (dbg_cmd.cmd_type != DBG_TYPE_MEM);
   assign is_gpr      = dbg_cmd.cmd_type == DBG_TYPE_GPR;
   assign is_csr      = dbg_cmd.cmd_type == DBG_TYPE_CSR;

   // gpr read puts the reg on rs1
   // gpr write moves the rs1 data into rd
   // csr accesses keep rd and rs1 at x0
   always_comb begin
      dbg_instr = '0;
      if (is_gpr && !dbg_cmd.write)
         dbg_instr = {12'b0, dbg_cmd.addr[4:0], F3_OR, 5'b0, OPC_OP};     // or x0, reg, x0
      else if (is_gpr && dbg_cmd.write)
         dbg_instr = {17'b0, F3_OR, dbg_cmd.addr[4:0], OPC_OP};           // or reg, x0, x0
      else if (is_csr && !dbg_cmd.write)
         dbg_instr = {dbg_cmd.addr, 5'b0, F3_CSRRS, 5'b0, OPC_SYSTEM};    // csrrs x0, csr, x0
      else if (is_csr && dbg_cmd.write)
         dbg_instr = {dbg_cmd.addr, 5'b0, F3_CSRRW, 5'b0, OPC_SYSTEM};    // csrrw x0, csr, x0
   end

   // debug replaces only the instruction word and keeps the lane fields
   always_comb begin
      load_i0 = fetch_i0.entry;
      if (debug_valid)
         load_i0.instr = dbg_instr;
   end

   assign wdata_rs1_nxt = debug_valid & dbg_cmd.write & (is_gpr | is_csr);
   assign fence_nxt     = debug_valid & dbg_cmd.write & is_csr &
                          (dbg_cmd.addr == DBG_FENCE_CSR);

   // flags are high while the synthesized inst sits in slot 0
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         debug_wdata_rs1 <= 1'b0;
         debug_fence     <= 1'b0;
      end else begin
         debug_wdata_rs1 <= wdata_rs1_nxt;
         debug_fence     <= fence_nxt;
      end
   end

endmodule

/* rtl/ib_pkg.sv */
// shared depth, entry structs, slot select codes and debug encodings for the decode instruction buffer
package ib_pkg;

   localparam int IB_DEPTH = 4;             // number of buffer slots

   // one buffered instruction with its pc and fault flags
   typedef struct packed {
      logic [31:0] instr;
      logic [31:1] pc;
      logic        pc4;                     // 4B inst else 2B
      logic        icaf;                    // access fault
      logic        perr;                    // parity error
      logic        sbecc;                   // single-bit ecc
      logic        dbecc;                   // double-bit ecc
   } ib_entry_t;

   // one lane from the aligner
   typedef struct packed {
      logic      valid;
      ib_entry_t entry;
   } fetch_t;

   // debug abstract command
   typedef struct packed {
      logic        valid;
      logic        write;
      logic [1:0]  cmd_type;
      logic [11:0] addr;                    // gpr in [4:0], csr in [11:0]
   } dbg_cmd_t;

   // load source of one slot
   typedef enum logic [2:0] {
      SEL_HOLD  = 3'd0,
      SEL_I0    = 3'd1,
      SEL_I1    = 3'd2,
      SEL_NEXT1 = 3'd3,                     // slot one above
      SEL_NEXT2 = 3'd4                      // slot two above
   } slot_sel_t;

   // debug command types
   localparam logic [1:0] DBG_TYPE_GPR = 2'd0;
   localparam logic [1:0] DBG_TYPE_CSR = 2'd1;
   localparam logic [1:0] DBG_TYPE_MEM = 2'd2;   // handled outside the buffer

   localparam logic [11:0] DBG_FENCE_CSR = 12'h7c4;   // debug-only fence csr

   // fields for the synthesized instructions
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [2:0] F3_CSRRW   = 3'b001;
   localparam logic [2:0] F3_CSRRS   = 3'b010;

endpackage
